/* Bender.yml */
package:
  name: lane_array

sources:
  - hdl/lane_net_pkg.sv
  - hdl/path_select.sv
  - hdl/bypass_buffer.sv
  - hdl/lane_network.sv
  - hdl/lane_array_top.sv
  - target: test
    include_dirs:
      - dv
    files:
      - dv/tb_lane_array.sv

/* dv/tb_lane_model.svh */
// Per-lane bypass buffer model and the reference operand function
`ifndef TB_LANE_MODEL_SVH
`define TB_LANE_MODEL_SVH

//////////////////////////////////////////////////////////////////////
// Buffer model
//////////////////////////////////////////////////////////////////////

index_t	model_idx	[NUM_LANES][$];		// Buffered writeback indices, oldest first
data_t	model_data	[NUM_LANES][$];		// Results paired with model_idx

function automatic int model_fill(input int l);
	return model_idx[l].size();
endfunction

function automatic void model_commit(input int l);
	if (model_idx[l].size() != 0) begin	// Commit on empty buffer does nothing
		model_idx[l].delete(0);
		model_data[l].delete(0);
	end
endfunction

function automatic void model_write(input int l, input index_t idx, input data_t data);
	model_idx[l].push_back(idx);
	model_data[l].push_back(data);
endfunction

//////////////////////////////////////////////////////////////////////
// Reference operand
//////////////////////////////////////////////////////////////////////

// Uses the request fields as they stand and the buffer model before
// any write or commit of the accept edge is applied
function automatic data_t expected_operand(input int l, input int s);
	data_t	value;
	path_t	code;

	code = path[l][s];
	if (code == PATH_LANE) begin
		return src_data[lane_sel[l][s]][s];		// Other lane, never bypassed
	end
	if (code == PATH_SCALAR) begin
		return scalar_data;						// Broadcast, never bypassed
	end
	value = src_data[l][s];						// Own path and code 3
	for (int k = 0; k < model_idx[l].size(); k++) begin
		if (model_idx[l][k] == src_idx[l][s]) begin
			value = model_data[l][k];			// Later match is newer
		end
	end
	return value;
endfunction

`endif

/* dv/tb_lane_array.sv */
// Testbench for the four-lane operand network: stimulus, compare process and report
`timescale 1ns/1ps

module tb_lane_array
	import lane_net_pkg::*;
();

	localparam int TIMEOUT_CYCLES = 100;

	logic									clock = 1'b0;
	logic									rst_n;
	logic									req_valid;
	logic									req_ready;
	data_t	[NUM_LANES-1:0][NUM_SRCS-1:0]	src_data;
	index_t	[NUM_LANES-1:0][NUM_SRCS-1:0]	src_idx;
	path_t	[NUM_LANES-1:0][NUM_SRCS-1:0]	path;
	lane_t	[NUM_LANES-1:0][NUM_SRCS-1:0]	lane_sel;
	data_t									scalar_data;
	logic									op_valid;
	logic									op_ready;
	data_t	[NUM_LANES-1:0][NUM_SRCS-1:0]	op_data;
	logic	[NUM_LANES-1:0]					wb_valid;
	index_t	[NUM_LANES-1:0]					wb_idx;
	data_t	[NUM_LANES-1:0]					wb_data;
	logic	[NUM_LANES-1:0]					wb_ready;
	logic	[NUM_LANES-1:0]					commit;
	logic	[NUM_LANES-1:0]					buffer_full;

	data_t	[NUM_LANES-1:0][NUM_SRCS-1:0]	exp_q	[$];	// Accepted, not yet delivered
	data_t	[NUM_LANES-1:0][NUM_SRCS-1:0]	exp_vec;
	data_t	[NUM_LANES-1:0][NUM_SRCS-1:0]	held_ops;
	logic									hold_pending = 1'b0;
	logic									wb_room;		// Model has a free entry

	int		error_count		= 0;
	int		check_count		= 0;
	int		accept_count	= 0;
	int		xfer_count		= 0;
	int		start_errors;

	`include "tb_lane_model.svh"

	always #20 clock = ~clock;

	lane_array_top UUT (
		.clock			(clock),
		.rst_n			(rst_n),
		.req_valid		(req_valid),
		.req_ready		(req_ready),
		.src_data		(src_data),
		.src_idx		(src_idx),
		.path			(path),
		.lane_sel		(lane_sel),
		.scalar_data	(scalar_data),
		.op_valid		(op_valid),
		.op_ready		(op_ready),
		.op_data		(op_data),
		.wb_valid		(wb_valid),
		.wb_idx			(wb_idx),
		.wb_data		(wb_data),
		.wb_ready		(wb_ready),
		.commit			(commit),
		.buffer_full	(buffer_full)
	);

	//////////////////////////////////////////////////////////////////////
	// Compare tasks and run control
	//////////////////////////////////////////////////////////////////////

	task automatic check_data(input string name, input data_t got, input data_t exp);
		check_count++;
		if (got !== exp) begin
			error_count++;
			$display("ERROR at %0t: %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		check_count++;
		if (got !== exp) begin
			error_count++;
			$display("ERROR at %0t: %s got %b expected %b", $time, name, got, exp);
		end
	endtask

	task automatic report_test(input int num, input string name, input int first_error);
		$display("test %0d %s: %0d errors", num, name, error_count - first_error);
	endtask

	task automatic finish_run();
		if (accept_count != xfer_count) begin
			error_count++;
			$display("Accepted %0d requests but saw %0d operand transfers",
				accept_count, xfer_count);
		end
		$display("Summary: %0d checks, %0d errors, %0d requests, %0d transfers",
			check_count, error_count, accept_count, xfer_count);
		if (error_count == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	endtask

	task automatic report_timeout(input string what);
		error_count++;
		$display("Gave up after %0d cycles waiting for %s", TIMEOUT_CYCLES, what);
		finish_run();
	endtask

	//////////////////////////////////////////////////////////////////////
	// Stimulus tasks
	//////////////////////////////////////////////////////////////////////

	task automatic next_cycle();
		@(posedge clock);
		#2;											// Drive just after the edge
	endtask

	// Mode 0 all own, mode 1 lane or scalar, otherwise any code
	task automatic fill_request(input int path_mode, input int idx_range);
		for (int l = 0; l < NUM_LANES; l++) begin
			for (int s = 0; s < NUM_SRCS; s++) begin
				src_data[l][s]	= data_t'($urandom);
				src_idx[l][s]	= index_t'($urandom_range(idx_range - 1, 0));
				lane_sel[l][s]	= lane_t'($urandom_range(NUM_LANES - 1, 0));
				case (path_mode)
					0:			path[l][s] = PATH_OWN;
					1:			path[l][s] = $urandom_range(1, 0) ? PATH_LANE : PATH_SCALAR;
					default:	path[l][s] = path_t'($urandom_range(3, 0));
				endcase
			end
		end
		scalar_data = data_t'($urandom);
	endtask

	task automatic send_request(input bit back_pressure);
		bit		accepted;
		int		waited;

		accepted	= 1'b0;
		waited		= 0;
		req_valid	= 1'b1;
		while (!accepted && waited < TIMEOUT_CYCLES) begin
			if (back_pressure) begin
				op_ready = 1'($urandom_range(1, 0));
			end
			@(negedge clock);
			accepted = req_ready;
			next_cycle();
			waited++;
		end
		req_valid = 1'b0;
		if (!accepted) begin
			report_timeout("req_ready");
		end
	endtask

	task automatic write_wb(input int l, input index_t idx, input data_t data);
		bit		taken;
		int		waited;

		taken		= 1'b0;
		waited		= 0;
		wb_valid[l]	= 1'b1;
		wb_idx[l]	= idx;
		wb_data[l]	= data;
		while (!taken && waited < TIMEOUT_CYCLES) begin
			@(negedge clock);
			taken = wb_ready[l];
			next_cycle();
			waited++;
		end
		wb_valid[l] = 1'b0;
		if (!taken) begin
			report_timeout($sformatf("wb_ready of lane %0d", l));
		end
	endtask

	task automatic drain_operands();
		int		waited;

		waited		= 0;
		op_ready	= 1'b1;
		while (exp_q.size() != 0 && waited < TIMEOUT_CYCLES) begin
			next_cycle();
			waited++;
		end
		if (exp_q.size() != 0) begin
			report_timeout("the last operand transfer");
		end
	endtask

	task automatic flush_buffers();
		int		waited;
		int		fill;

		waited	= 0;
		fill	= 1;
		while (fill != 0 && waited < TIMEOUT_CYCLES) begin
			commit = '1;							// Empty lanes ignore it
			next_cycle();
			waited++;
			fill = 0;
			for (int l = 0; l < NUM_LANES; l++) begin
				fill += model_fill(l);
			end
		end
		commit = '0;
		if (fill != 0) begin
			report_timeout("the bypass buffers to empty");
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Compare process
	//////////////////////////////////////////////////////////////////////

	// Sampled at the falling edge, where inputs and outputs are settled
	// and describe the transfers of the next rising edge
	always @(negedge clock) begin
		if (rst_n) begin
			check_flag("op_valid", op_valid, exp_q.size() != 0);
			check_flag("req_ready", req_ready, op_ready || (exp_q.size() == 0));
			if (hold_pending) begin
				for (int l = 0; l < NUM_LANES; l++) begin
					for (int s = 0; s < NUM_SRCS; s++) begin
						check_data($sformatf("op_data[%0d][%0d] held", l, s),
							op_data[l][s], held_ops[l][s]);
					end
				end
				hold_pending = 1'b0;
			end
			if (op_valid && op_ready && exp_q.size() != 0) begin
				exp_vec = exp_q.pop_front();
				xfer_count++;
				for (int l = 0; l < NUM_LANES; l++) begin
					for (int s = 0; s < NUM_SRCS; s++) begin
						check_data($sformatf("op_data[%0d][%0d]", l, s),
							op_data[l][s], exp_vec[l][s]);
					end
				end
			end else if (op_valid && !op_ready) begin
				held_ops		= op_data;			// Must survive the stall
				hold_pending	= 1'b1;
			end
			if (req_valid && req_ready) begin
				for (int l = 0; l < NUM_LANES; l++) begin
					for (int s = 0; s < NUM_SRCS; s++) begin
						exp_vec[l][s] = expected_operand(l, s);
					end
				end
				exp_q.push_back(exp_vec);
				accept_count++;
			end
			for (int l = 0; l < NUM_LANES; l++) begin
				wb_room = model_fill(l) < BYPASS_DEPTH;
				check_flag($sformatf("wb_ready[%0d]", l), wb_ready[l], wb_room);
				check_flag($sformatf("buffer_full[%0d]", l), buffer_full[l], !wb_room);
				if (commit[l]) begin
					model_commit(l);				// Uses the fill before the write
				end
				if (wb_valid[l] && wb_room) begin
					model_write(l, wb_idx[l], wb_data[l]);
				end
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////////////////////////

	initial begin
		void'($urandom(32'h34015632));
		rst_n		= 1'b0;
		req_valid	= 1'b0;
		src_data	= '0;
		src_idx		= '0;
		path		= '0;
		lane_sel	= '0;
		scalar_data	= '0;
		op_ready	= 1'b1;
		wb_valid	= '0;
		wb_idx		= '0;
		wb_data		= '0;
		commit		= '0;
		repeat (2) @(posedge clock);
		#2 rst_n = 1'b1;

		// Reset state, then own path with empty buffers
		start_errors = error_count;
		@(negedge clock);
		check_flag("op_valid after reset", op_valid, 1'b0);
		check_flag("req_ready after reset", req_ready, 1'b1);
		for (int l = 0; l < NUM_LANES; l++) begin
			check_flag($sformatf("wb_ready[%0d] after reset", l), wb_ready[l], 1'b1);
			check_flag($sformatf("buffer_full[%0d] after reset", l), buffer_full[l], 1'b0);
		end
		next_cycle();
		for (int n = 0; n < 12; n++) begin
			fill_request(0, 32);
			send_request(1'b0);
		end
		drain_operands();
		report_test(1, "reset and own path", start_errors);

		// Exchange and scalar paths skip the buffer
		start_errors = error_count;
		for (int l = 0; l < NUM_LANES; l++) begin
			for (int k = 0; k < 3; k++) begin
				write_wb(l, index_t'(k), data_t'($urandom));
			end
		end
		for (int n = 0; n < 12; n++) begin
			fill_request(1, 4);						// Indices overlap the entries
			send_request(1'b0);
		end
		drain_operands();
		flush_buffers();
		report_test(2, "lane and scalar paths", start_errors);

		// Newest matching writeback wins
		start_errors = error_count;
		for (int l = 0; l < NUM_LANES; l++) begin
			write_wb(l, index_t'(5), data_t'($urandom));
			write_wb(l, index_t'(7), data_t'($urandom));
			write_wb(l, index_t'(5), data_t'($urandom));
		end
		for (int n = 0; n < 16; n++) begin
			fill_request((n < 8) ? 0 : 2, 10);
			for (int l = 0; l < NUM_LANES; l++) begin
				src_idx[l][0] = index_t'(5);
				src_idx[l][1] = index_t'(7);
			end
			send_request(1'b0);
		end
		drain_operands();
		flush_buffers();
		report_test(3, "newest match forwarding", start_errors);

		// Full buffer refuses writes, commit retires the oldest
		start_errors = error_count;
		for (int l = 0; l < NUM_LANES; l++) begin
			for (int k = 0; k < BYPASS_DEPTH; k++) begin
				write_wb(l, index_t'(10 + k), data_t'($urandom));
			end
		end
		@(negedge clock);
		for (int l = 0; l < NUM_LANES; l++) begin
			check_flag($sformatf("buffer_full[%0d] when full", l), buffer_full[l], 1'b1);
			check_flag($sformatf("wb_ready[%0d] when full", l), wb_ready[l], 1'b0);
		end
		next_cycle();
		for (int l = 0; l < NUM_LANES; l++) begin
			wb_valid[l]	= 1'b1;
			wb_idx[l]	= index_t'(14);				// Refused write
			wb_data[l]	= data_t'($urandom);
		end
		repeat (3) next_cycle();
		wb_valid = '0;
		for (int pass = 0; pass < 2; pass++) begin
			fill_request(0, 32);
			for (int l = 0; l < NUM_LANES; l++) begin
				src_idx[l][0] = index_t'(10);		// Oldest entry
				src_idx[l][1] = index_t'(11);
				src_idx[l][2] = index_t'(14);
			end
			send_request(1'b0);
			if (pass == 0) begin
				commit = '1;
				next_cycle();
				commit = '0;
				@(negedge clock);
				for (int l = 0; l < NUM_LANES; l++) begin
					check_flag($sformatf("buffer_full[%0d] after commit", l),
						buffer_full[l], 1'b0);
				end
				next_cycle();
			end
		end
		drain_operands();
		flush_buffers();
		report_test(4, "full flag and commit", start_errors);

		// Random back-pressure on the operand side
		start_errors = error_count;
		for (int l = 0; l < NUM_LANES; l++) begin
			for (int k = 0; k < 3; k++) begin
				write_wb(l, index_t'($urandom_range(7, 0)), data_t'($urandom));
			end
		end
		for (int n = 0; n < 40; n++) begin
			fill_request(2, 8);
			send_request(1'b1);
		end
		drain_operands();
		flush_buffers();
		report_test(5, "operand back-pressure", start_errors);

		finish_run();
	end

endmodule

/* hdl/bypass_buffer.sv */
// Per-lane writeback FIFO with newest-match forwarding, commit retire and full flag
`timescale 1ns/1ps

module bypass_buffer
	import lane_net_pkg::*;
(
	input									clock,
	input									rst_n,
	input									wb_valid,		// Writeback offered
	input	index_t							wb_idx,			// Writeback register index
	input	data_t							wb_data,		// Writeback result
	output	logic							wb_ready,		// Room for a writeback
	input									commit,			// Retire oldest entry
	input	index_t	[NUM_SRCS-1:0]			src_idx,		// Source register indices
	input	data_t	[NUM_SRCS-1:0]			src_data,		// Operands after path select
	input	logic	[NUM_SRCS-1:0]			bypass_en,		// Search enable per source
	output	data_t	[NUM_SRCS-1:0]			fwd_data,		// Operands after bypass
	output	logic							buffer_full
);

	index_t		idx_mem		[BYPASS_DEPTH];
	data_t		data_mem	[BYPASS_DEPTH];

	ptr_t		wr_ptr;
	ptr_t		rd_ptr;
	count_t		count;

	logic		push;
	logic		pop;

	//////////////////////////////////////////////////////////////////////
	// Handshake and fill control
	//////////////////////////////////////////////////////////////////////

	assign buffer_full	= (count == count_t'(BYPASS_DEPTH));
	assign wb_ready		= ~buffer_full;

	assign push			= wb_valid & wb_ready;
	assign pop			= commit & (count != '0);	// Commit on empty is dropped

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr	<= '0;
			rd_ptr	<= '0;
			count	<= '0;
		end else begin
			if (push) begin
				wr_ptr	<= wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr	<= rd_ptr + 1'b1;
			end
			case ({push, pop})
				2'b10:		count <= count + 1'b1;
				2'b01:		count <= count - 1'b1;
				default:	count <= count;			// Both or neither
			endcase
		end
	end

	// Entry storage
	always_ff @(posedge clock) begin
		if (push) begin
			idx_mem[wr_ptr]		<= wb_idx;
			data_mem[wr_ptr]	<= wb_data;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Forwarding search
	//////////////////////////////////////////////////////////////////////

	// Walk from oldest to newest so a later match overrides an
	// earlier one and the newest writeback to an index wins
	always_comb begin
		ptr_t	slot;

		for (int s = 0; s < NUM_SRCS; s++) begin
			fwd_data[s] = src_data[s];						// No match falls through
			for (int k = 0; k < BYPASS_DEPTH; k++) begin
				slot = rd_ptr + ptr_t'(k);
				if (bypass_en[s] && (count_t'(k) < count) &&
						(idx_mem[slot] == src_idx[s])) begin
					fwd_data[s] = data_mem[slot];
				end
			end
		end
	end

endmodule

/* hdl/lane_array_top.sv */
// Four-lane operand network top with request and operand handshakes
`timescale 1ns/1ps

module lane_array_top
	import lane_net_pkg::*;
(
	input											clock,
	input											rst_n,

	// Request
	input											req_valid,
	output	logic									req_ready,
	input	data_t	[NUM_LANES-1:0][NUM_SRCS-1:0]	src_data,		// Register file reads
	input	index_t	[NUM_LANES-1:0][NUM_SRCS-1:0]	src_idx,
	input	path_t	[NUM_LANES-1:0][NUM_SRCS-1:0]	path,
	input	lane_t	[NUM_LANES-1:0][NUM_SRCS-1:0]	lane_sel,
	input	data_t									scalar_data,	// From scalar unit

	// Operands
	output	logic									op_valid,
	input											op_ready,
	output	data_t	[NUM_LANES-1:0][NUM_SRCS-1:0]	op_data,

	// Writeback and commit
	input	logic	[NUM_LANES-1:0]					wb_valid,
	input	index_t	[NUM_LANES-1:0]					wb_idx,
	input	data_t	[NUM_LANES-1:0]					wb_data,
	output	logic	[NUM_LANES-1:0]					wb_ready,
	input	logic	[NUM_LANES-1:0]					commit,
	output	logic	[NUM_LANES-1:0]					buffer_full
);

	logic	stall;
	logic	load;

	//////////////////////////////////////////////////////////////////////
	// Issue handshake
	//////////////////////////////////////////////////////////////////////

	assign req_ready	= op_ready | ~op_valid;		// Output slot free or draining
	assign stall		= ~req_ready;
	assign load			= req_valid & req_ready;

	// Operands follow an accepted request by one cycle
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			op_valid	<= 1'b0;
		end else if (req_ready) begin
			op_valid	<= req_valid;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Lanes
	//////////////////////////////////////////////////////////////////////

	for (genvar l = 0; l < NUM_LANES; l++) begin : g_lane
		lane_network u_lane (
			.clock			(clock),
			.rst_n			(rst_n),
			.stall			(stall),
			.load			(load),
			.src_data		(src_data[l]),
			.src_idx		(src_idx[l]),
			.path			(path[l]),
			.lane_sel		(lane_sel[l]),
			.lane_data		(src_data),				// Every lane sees all lanes
			.scalar_data	(scalar_data),
			.wb_valid		(wb_valid[l]),
			.wb_idx			(wb_idx[l]),
			.wb_data		(wb_data[l]),
			.wb_ready		(wb_ready[l]),
			.commit			(commit[l]),
			.buffer_full	(buffer_full[l]),
			.op_data		(op_data[l])
		);
	end

endmodule

/* hdl/lane_net_pkg.sv */
// Lane count, operand and index widths, path codes and bypass buffer sizing
package lane_net_pkg;

	//////////////////////////////////////////////////////////////////////
	// Array dimensions
	//////////////////////////////////////////////////////////////////////

	localparam int NUM_LANES	= 4;		// SIMD lanes
	localparam int NUM_SRCS		= 3;		// Source operands per lane
	localparam int BYPASS_DEPTH	= 4;		// Writeback entries per lane

	localparam int DATA_W		= 32;
	localparam int LANE_W		= $clog2(NUM_LANES);
	localparam int INDEX_W		= 5;
	localparam int PATH_W		= 2;
	localparam int COUNT_W		= $clog2(BYPASS_DEPTH + 1);
	localparam int PTR_W		= $clog2(BYPASS_DEPTH);

	//////////////////////////////////////////////////////////////////////
	// Word types
	//////////////////////////////////////////////////////////////////////

	typedef logic [DATA_W-1:0]	data_t;		// Operand or result word
	typedef logic [LANE_W-1:0]	lane_t;		// Lane number
	typedef logic [INDEX_W-1:0]	index_t;	// Register index
	typedef logic [PATH_W-1:0]	path_t;		// Per-source path code
	typedef logic [COUNT_W-1:0]	count_t;	// Bypass fill level
	typedef logic [PTR_W-1:0]	ptr_t;		// Bypass slot pointer

	//////////////////////////////////////////////////////////////////////
	// Path codes
	//////////////////////////////////////////////////////////////////////

	// Code 3 is unused and behaves like PATH_OWN
	localparam path_t PATH_OWN		= 2'd0;	// Lane's own register data
	localparam path_t PATH_LANE		= 2'd1;	// Same source from another lane
	localparam path_t PATH_SCALAR	= 2'd2;	// Broadcast from scalar unit

endpackage

/* hdl/lane_network.sv */
// One lane's operand network with path select, bypass buffer and operand register
`timescale 1ns/1ps

module lane_network
	import lane_net_pkg::*;
(
	input											clock,
	input											rst_n,
	input											stall,			// Operand stage held
	input											load,			// Request accepted
	input	data_t	[NUM_SRCS-1:0]					src_data,		// Own register values
	input	index_t	[NUM_SRCS-1:0]					src_idx,		// Own register indices
	input	path_t	[NUM_SRCS-1:0]					path,
	input	lane_t	[NUM_SRCS-1:0]					lane_sel,
	input	data_t	[NUM_LANES-1:0][NUM_SRCS-1:0]	lane_data,		// Register data of all lanes
	input	data_t									scalar_data,
	input											wb_valid,
	input	index_t									wb_idx,
	input	data_t									wb_data,
	output	logic									wb_ready,
	input											commit,
	output	logic									buffer_full,
	output	data_t	[NUM_SRCS-1:0]					op_data			// To execution unit
);

	data_t	[NUM_SRCS-1:0]		sel_data;
	data_t	[NUM_SRCS-1:0]		fwd_data;
	logic	[NUM_SRCS-1:0]		bypass_en;

	//////////////////////////////////////////////////////////////////////
	// Bypass enable
	//////////////////////////////////////////////////////////////////////

	// Indices of a foreign lane or the scalar unit do not name an
	// entry of this lane's buffer, so only own and code 3 search it
	always_comb begin
		for (int s = 0; s < NUM_SRCS; s++) begin
			bypass_en[s] = (path[s] != PATH_LANE) && (path[s] != PATH_SCALAR);
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Datapath
	//////////////////////////////////////////////////////////////////////

	path_select u_path_select (
		.src_data		(src_data),
		.path			(path),
		.lane_sel		(lane_sel),
		.lane_data		(lane_data),
		.scalar_data	(scalar_data),
		.sel_data		(sel_data)
	);

	bypass_buffer u_bypass_buffer (
		.clock			(clock),
		.rst_n			(rst_n),
		.wb_valid		(wb_valid),
		.wb_idx			(wb_idx),
		.wb_data		(wb_data),
		.wb_ready		(wb_ready),
		.commit			(commit),
		.src_idx		(src_idx),
		.src_data		(sel_data),
		.bypass_en		(bypass_en),
		.fwd_data		(fwd_data),
		.buffer_full	(buffer_full)
	);

	// Operand register
	always_ff @(posedge clock) begin
		if (load && !stall) begin
			op_data	<= fwd_data;						// Capture at accept edge
		end
	end

endmodule

/* hdl/path_select.sv */
// Per-source operand selector between own register, another lane and the scalar
`timescale 1ns/1ps

module path_select
	import lane_net_pkg::*;
(
	input	data_t	[NUM_SRCS-1:0]					src_data,		// Own register values
	input	path_t	[NUM_SRCS-1:0]					path,			// Path code per source
	input	lane_t	[NUM_SRCS-1:0]					lane_sel,		// Lane for PATH_LANE
	input	data_t	[NUM_LANES-1:0][NUM_SRCS-1:0]	lane_data,		// All lanes, source aligned
	input	data_t									scalar_data,	// Scalar broadcast
	output	data_t	[NUM_SRCS-1:0]					sel_data		// Selected operands
);

	//////////////////////////////////////////////////////////////////////
	// Selection
	//////////////////////////////////////////////////////////////////////

	// Rotation and exchange path picks the same source slot of the
	// named lane, so source 2 of this lane reads source 2 over there
	always_comb begin
		for (int s = 0; s < NUM_SRCS; s++) begin
			case (path[s])
				PATH_LANE: begin
					sel_data[s] = lane_data[lane_sel[s]][s];	// Exchange path
				end
				PATH_SCALAR: begin
					sel_data[s] = scalar_data;					// Scalar broadcast
				end
				default: begin
					sel_data[s] = src_data[s];					// Own and code 3
				end
			endcase
		end
	end

endmodule

/* sim.f */
+incdir+dv
hdl/lane_net_pkg.sv
hdl/path_select.sv
hdl/bypass_buffer.sv
hdl/lane_network.sv
hdl/lane_array_top.sv
dv/tb_lane_array.sv
